// ==== hdl/rv_isa_pkg.sv ====
// --------------------
// RV32I encodings
// --------------------

package rv_isa_pkg;

    // --------------------
    // Major opcodes
    // --------------------
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111
    } opcode_e;

    // ALU function codes, shared by OP and OP-IMM
    typedef enum logic [2:0] {
        ADD  = 3'b000,
        SLL  = 3'b001,
        SLT  = 3'b010,
        SLTU = 3'b011,
        XOR  = 3'b100,
        SR   = 3'b101,
        OR   = 3'b110,
        AND  = 3'b111
    } funct3_e;

    // Selects sub and sra / srai
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // --------------------
    // Instruction formats
    // --------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_e    funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        funct3_e     funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } inst_i_t;

    // Same word, two views
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

endpackage

// ==== hdl/core_pkg.sv ====
// --------------------
// Pipeline types
// --------------------

package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // Fetch to decode
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } fetch_t;

    // Decode to execute
    typedef struct packed {
        logic                valid;
        word_t               pc;
        reg_idx_t            rd;
        word_t               rs1_val;
        word_t               rs2_val;
        word_t               imm;
        rv_isa_pkg::opcode_e opcode;
        rv_isa_pkg::funct3_e funct3;
        logic                alt;
    } decode_t;

    // Retirement, also the register write port
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    value;
    } retire_t;

endpackage

// ==== hdl/inst_fetch.sv ====
// --------------------
// Instruction fetch
// --------------------
`timescale 1ns/100ps

module inst_fetch import core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_exec,
    input  logic   i_stall,
    input  word_t  i_imem_data,
    output word_t  o_imem_addr,
    output word_t  o_pc,
    output fetch_t o_fetch
);

    word_t  pc;
    fetch_t fetch_q;

    // Memory answers in the same cycle
    assign o_imem_addr = pc;
    assign o_pc        = pc;
    assign o_fetch     = fetch_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc            <= RESET_PC;
            fetch_q.valid <= 1'b0;
        end else if (!i_stall) begin
            // Bubble while not running
            fetch_q.valid <= i_exec;
            fetch_q.pc    <= pc;
            fetch_q.inst  <= i_imem_data;
            if (i_exec) begin
                pc <= pc + word_t'(4);
            end
        end
    end

endmodule

// ==== hdl/decode.sv ====
// --------------------
// Decode and reg read
// --------------------
`timescale 1ns/100ps

module decode import core_pkg::*, rv_isa_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_stall,
    input  fetch_t   i_fetch,
    output reg_idx_t o_rs1,
    output reg_idx_t o_rs2,
    input  word_t    i_rs1_val,
    input  word_t    i_rs2_val,
    output decode_t  o_decode
);

    inst_u   inst;
    logic    kept;
    word_t   imm;
    decode_t dec_next;
    decode_t dec_q;

    assign inst  = i_fetch.inst;
    assign o_rs1 = inst.r.rs1;
    assign o_rs2 = inst.r.rs2;

    assign kept = (inst.r.opcode == OP_IMM) || (inst.r.opcode == OP) ||
                  (inst.r.opcode == LUI);

    // U-type for lui, I-type otherwise
    always_comb begin
        if (inst.i.opcode == LUI) begin
            imm = {inst.i.imm12, inst.i.rs1, inst.i.funct3, 12'b0};
        end else begin
            imm = {{20{inst.i.imm12[11]}}, inst.i.imm12};
        end
    end

    always_comb begin
        dec_next.valid   = i_fetch.valid && kept;
        dec_next.pc      = i_fetch.pc;
        dec_next.rd      = inst.r.rd;
        dec_next.rs1_val = i_rs1_val;
        dec_next.rs2_val = i_rs2_val;
        dec_next.imm     = imm;
        dec_next.opcode  = inst.r.opcode;
        dec_next.funct3  = inst.r.funct3;
        // sub and sra, or srai with the shift-type bits
        dec_next.alt     = ((inst.r.opcode == OP) || (inst.r.funct3 == SR)) &&
                           (inst.r.funct7 == FUNCT7_ALT);
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            dec_q.valid <= 1'b0;
        end else if (!i_stall) begin
            dec_q <= dec_next;
        end
    end

    assign o_decode = dec_q;

endmodule

// ==== hdl/reg_file.sv ====
// --------------------
// Register file
// --------------------
`timescale 1ns/100ps

module reg_file import core_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    output word_t    o_rs1_val,
    output word_t    o_rs2_val,
    input  retire_t  i_wr
);

    word_t regs [1:31];

    // x0 reads zero and a same-cycle write passes through
    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (i_wr.valid && (i_wr.rd == idx)) begin
            return i_wr.value;
        end
        return regs[idx];
    endfunction

    always_comb begin
        o_rs1_val = read_port(i_rs1);
        o_rs2_val = read_port(i_rs2);
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr.valid && (i_wr.rd != '0)) begin
            regs[i_wr.rd] <= i_wr.value;
        end
    end

endmodule

// ==== hdl/alu.sv ====
// --------------------
// Execute and retire
// --------------------
`timescale 1ns/100ps

module alu import core_pkg::*, rv_isa_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_stall,
    input  decode_t i_decode,
    output retire_t o_retire
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      result;
    retire_t    ret_q;

    // --------------------
    // Operands
    // --------------------
    assign op_a  = i_decode.rs1_val;
    assign op_b  = (i_decode.opcode == OP) ? i_decode.rs2_val : i_decode.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_decode.funct3)
            ADD:     result = i_decode.alt ? (op_a - op_b) : (op_a + op_b);
            SLL:     result = op_a << shamt;
            SLT:     result = word_t'($signed(op_a) < $signed(op_b));
            SLTU:    result = word_t'(op_a < op_b);
            XOR:     result = op_a ^ op_b;
            SR:      result = i_decode.alt ? word_t'($signed(op_a) >>> shamt)
                                           : (op_a >> shamt);
            OR:      result = op_a | op_b;
            AND:     result = op_a & op_b;
            default: result = '0;
        endcase
        // lui takes the immediate as is
        if (i_decode.opcode == LUI) begin
            result = i_decode.imm;
        end
    end

    // --------------------
    // Retire register
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ret_q.valid <= 1'b0;
        end else if (!i_stall) begin
            ret_q.valid <= i_decode.valid;
            ret_q.pc    <= i_decode.pc;
            ret_q.rd    <= i_decode.rd;
            ret_q.value <= result;
        end
    end

    // Held record must not retire twice
    always_comb begin
        o_retire       = ret_q;
        o_retire.valid = ret_q.valid && !i_stall;
    end

endmodule

// ==== hdl/core.sv ====
// --------------------
// RV32I pipeline core
// --------------------
`timescale 1ns/100ps

module core import core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_exec,
    output word_t   o_imem_addr,
    input  word_t   i_imem_data,
    input  logic    i_imem_wait,
    output word_t   o_pc,
    output retire_t o_retire
);

    fetch_t   fetch;
    decode_t  dec;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_val;
    word_t    rs2_val;

    inst_fetch #(
        .RESET_PC (RESET_PC)
    ) u_inst_fetch (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_exec      (i_exec),
        .i_stall     (i_imem_wait),
        .i_imem_data (i_imem_data),
        .o_imem_addr (o_imem_addr),
        .o_pc        (o_pc),
        .o_fetch     (fetch)
    );

    decode u_decode (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_stall   (i_imem_wait),
        .i_fetch   (fetch),
        .o_rs1     (rs1),
        .o_rs2     (rs2),
        .i_rs1_val (rs1_val),
        .i_rs2_val (rs2_val),
        .o_decode  (dec)
    );

    // Written straight from the retire record
    reg_file u_reg_file (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rs1     (rs1),
        .i_rs2     (rs2),
        .o_rs1_val (rs1_val),
        .o_rs2_val (rs2_val),
        .i_wr      (o_retire)
    );

    alu u_alu (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_stall  (i_imem_wait),
        .i_decode (dec),
        .o_retire (o_retire)
    );

endmodule

// ==== verif/core_tb_assert.sv ====
// --------------------
// Core port checks
// --------------------
`timescale 1ns/100ps

module core_tb_assert import core_pkg::*; (
    input logic    i_clk,
    input logic    i_rst,
    input logic    i_exec,
    input logic    i_imem_wait,
    input word_t   o_pc,
    input retire_t o_retire
);

    retire_known: assert property (@(posedge i_clk) disable iff (i_rst)
        !$isunknown(o_retire.valid))
        else $error("retire valid is unknown");

    // Frozen pc on wait or halt
    pc_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_imem_wait || !i_exec) |=> $stable(o_pc))
        else $error("pc moved during a wait or while halted");

    retire_in_wait: assert property (@(posedge i_clk) disable iff (i_rst)
        i_imem_wait |-> !o_retire.valid)
        else $error("retirement during an instruction memory wait");

endmodule

bind core core_tb_assert u_core_tb_assert (.*);

// ==== verif/core_tb.sv ====
// --------------------
// Core testbench
// --------------------
`timescale 1ns/100ps

module core_tb import core_pkg::*, rv_isa_pkg::*; ();

    localparam word_t RESET_PC    = 32'h0000_0100;
    localparam int    NUM_ROWS    = 26;
    localparam int    WATCHDOG_NS = (NUM_ROWS * 4 + 200) * 8;

    typedef struct packed {
        inst_u    inst;
        reg_idx_t rd;
        word_t    value;
    } row_t;

    row_t    prog [NUM_ROWS];
    word_t   ref_regs [32];
    logic    i_clk = 1'b0;
    logic    i_rst;
    logic    i_exec;
    logic    i_imem_wait;
    word_t   o_imem_addr;
    word_t   i_imem_data;
    word_t   o_pc;
    retire_t o_retire;
    logic    stall_en;
    integer  seed;
    word_t   held_pc;
    int      errors;
    int      checks;
    int      ret_idx;
    int      n_put;
    int      errs_before;

    core #(
        .RESET_PC (RESET_PC)
    ) DUT (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_exec      (i_exec),
        .o_imem_addr (o_imem_addr),
        .i_imem_data (i_imem_data),
        .i_imem_wait (i_imem_wait),
        .o_pc        (o_pc),
        .o_retire    (o_retire)
    );

    always #4 i_clk = ~i_clk;

    // --------------------
    // Instruction memory
    // --------------------
    function automatic word_t imem_read(word_t addr);
        word_t offs;
        offs = addr - RESET_PC;
        if ((addr[1:0] == 2'b00) && (offs < NUM_ROWS * 4)) begin
            return prog[offs >> 2].inst;
        end
        // Undecodable filler that never retires
        return {addr[24:0] ^ addr[31:7], 7'h7f};
    endfunction

    always_comb i_imem_data = imem_read(o_imem_addr);

    always @(negedge i_clk) begin
        if (stall_en) begin
            i_imem_wait <= ({$random(seed)} % 100) < 30;
        end else begin
            i_imem_wait <= 1'b0;
        end
    end

    // --------------------
    // Encoders and model
    // --------------------
    function automatic inst_u enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    funct3_e f3, reg_idx_t rd);
        inst_u w;
        w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OP};
        return w;
    endfunction

    function automatic inst_u enc_i(logic [11:0] imm, reg_idx_t rs1, funct3_e f3,
                                    reg_idx_t rd);
        inst_u w;
        w.i = '{imm12: imm, rs1: rs1, funct3: f3, rd: rd, opcode: OP_IMM};
        return w;
    endfunction

    // U format spread over the I fields
    function automatic inst_u enc_lui(logic [19:0] imm20, reg_idx_t rd);
        inst_u w;
        w.i = '{imm12: imm20[19:8], rs1: imm20[7:3], funct3: funct3_e'(imm20[2:0]),
                rd: rd, opcode: LUI};
        return w;
    endfunction

    function automatic void put(inst_u w);
        prog[n_put].inst = w;
        n_put++;
    endfunction

    function automatic word_t shift_right_arith(word_t v, int n);
        word_t r;
        r = v;
        for (int k = 0; k < n; k++) begin
            r = {r[31], r[31:1]};
        end
        return r;
    endfunction

    function automatic word_t ref_result(inst_u w);
        word_t a;
        word_t b;
        if (w.r.opcode == LUI) begin
            return word_t'(w) & 32'hffff_f000;
        end
        a = ref_regs[w.r.rs1];
        b = (w.r.opcode == OP) ? ref_regs[w.r.rs2] : {{20{w.i.imm12[11]}}, w.i.imm12};
        case (w.r.funct3)
            ADD:     return ((w.r.opcode == OP) && w.r.funct7[5]) ? a - b : a + b;
            SLL:     return a << b[4:0];
            SLT:     return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
            SLTU:    return word_t'(a < b);
            XOR:     return a ^ b;
            SR:      return w.r.funct7[5] ? shift_right_arith(a, b[4:0]) : a >> b[4:0];
            OR:      return a | b;
            AND:     return a & b;
            default: return '0;
        endcase
    endfunction

    task automatic build_program();
        put(enc_i(12'd100, 5'd0, ADD, 5'd1));
        put(enc_i(12'hff9, 5'd0, ADD, 5'd2));
        put(enc_lui(20'h80000, 5'd3));
        put(enc_i(12'd5, 5'd2, SLT, 5'd4));
        put(enc_i(12'd5, 5'd2, SLTU, 5'd5));
        put(enc_i(12'h0f0, 5'd1, XOR, 5'd6));
        put(enc_i(12'h7f0, 5'd2, AND, 5'd7));
        put(enc_i(12'h123, 5'd3, OR, 5'd8));
        put(enc_i(12'd3, 5'd1, SLL, 5'd9));
        put(enc_i(12'd4, 5'd2, SR, 5'd10));
        put(enc_i(12'h402, 5'd2, SR, 5'd11));
        put(enc_r(7'h00, 5'd2, 5'd1, ADD, 5'd12));
        put(enc_r(FUNCT7_ALT, 5'd2, 5'd1, ADD, 5'd13));
        put(enc_r(7'h00, 5'd4, 5'd1, SLL, 5'd14));
        put(enc_r(7'h00, 5'd1, 5'd2, SLT, 5'd15));
        put(enc_r(7'h00, 5'd1, 5'd2, SLTU, 5'd16));
        put(enc_r(7'h00, 5'd7, 5'd6, XOR, 5'd17));
        put(enc_r(7'h00, 5'd4, 5'd3, SR, 5'd18));
        put(enc_r(FUNCT7_ALT, 5'd4, 5'd3, SR, 5'd19));
        put(enc_r(7'h00, 5'd9, 5'd8, OR, 5'd20));
        put(enc_r(7'h00, 5'd6, 5'd2, AND, 5'd21));
        put(enc_i(12'd77, 5'd1, ADD, 5'd0));
        put(enc_lui(20'h12345, 5'd22));
        put(enc_r(7'h00, 5'd2, 5'd0, ADD, 5'd23));
        put(enc_i(12'h678, 5'd22, ADD, 5'd24));
        put(enc_i(12'd0, 5'd0, ADD, 5'd0));
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            prog[i].rd    = prog[i].inst.r.rd;
            prog[i].value = ref_result(prog[i].inst);
            if (prog[i].rd != 5'd0) begin
                ref_regs[prog[i].rd] = prog[i].value;
            end
        end
    endtask

    // --------------------
    // Checks
    // --------------------
    task automatic check_retire(retire_t got, retire_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: retire got pc %h rd %0d val %h, expected pc %h rd %0d val %h",
                     $time, got.pc, got.rd, got.value, exp.pc, exp.rd, exp.value);
            errors++;
        end
    endtask

    task automatic check_word(word_t got, word_t exp, string msg);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_valid(logic got, logic exp, string msg);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
            errors++;
        end
    endtask

    // Sampled after the falling-edge drive has settled
    always @(negedge i_clk) begin
        #1;
        if (!i_rst && o_retire.valid) begin
            if (ret_idx < NUM_ROWS) begin
                check_retire(o_retire, '{valid: 1'b1, pc: RESET_PC + word_t'(ret_idx * 4),
                                         rd: prog[ret_idx].rd, value: prog[ret_idx].value});
            end else begin
                $display("Unexpected retirement after the last instruction, pc %h", o_retire.pc);
                errors++;
            end
            ret_idx++;
        end
    end

    task automatic report(string name);
        $display("Test %-12s %s", name, (errors == errs_before) ? "ok" : "with errors");
        errs_before = errors;
    endtask

    task automatic run_program(logic with_stalls, int pause_at);
        @(negedge i_clk);
        i_rst  = 1'b1;
        i_exec = 1'b0;
        repeat (2) @(negedge i_clk);
        i_rst    = 1'b0;
        ret_idx  = 0;
        stall_en <= with_stalls;
        i_exec   = 1'b1;
        if (pause_at > 0) begin
            wait (ret_idx >= pause_at);
            @(negedge i_clk);
            i_exec  = 1'b0;
            // Four slots past the last row retired
            held_pc = RESET_PC + word_t'((pause_at + 3) * 4);
            for (int c = 0; c < 8; c++) begin
                @(negedge i_clk);
                check_word(o_pc, held_pc, "pc while halted");
                check_word(o_imem_addr, held_pc, "fetch address while halted");
                if (c >= 3) begin
                    check_valid(o_retire.valid, 1'b0, "retire valid while halted");
                end
            end
            i_exec = 1'b1;
        end
        wait (ret_idx >= NUM_ROWS);
        // Room for a stray extra retirement
        repeat (6) @(negedge i_clk);
        stall_en <= 1'b0;
        i_exec   = 1'b0;
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        i_rst       = 1'b1;
        i_exec      = 1'b0;
        i_imem_wait <= 1'b0;
        stall_en    <= 1'b0;
        seed        = 32'hcd52_ca81;
        errors      = 0;
        checks      = 0;
        ret_idx     = 0;
        n_put       = 0;
        errs_before = 0;
        build_program();
        repeat (2) begin
            @(negedge i_clk);
            check_valid(o_retire.valid, 1'b0, "retire valid in reset");
            check_word(o_pc, RESET_PC, "pc in reset");
        end
        i_rst = 1'b0;
        @(negedge i_clk);
        check_valid(o_retire.valid, 1'b0, "retire valid after reset");
        check_word(o_pc, RESET_PC, "pc after reset");
        report("reset");
        run_program(1'b0, 0);
        report("program");
        run_program(1'b1, 0);
        report("stalls");
        run_program(1'b0, 10);
        report("run control");
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/inst_fetch.sv
hdl/decode.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/core.sv
verif/core_tb_assert.sv
verif/core_tb.sv
